// File: design/codec_ifs.sv
// Codec internal interfaces for the captured sample and the converted words
`timescale 1ns/1ns

// Registered input sample, one per cycle
interface capture_if;
    display_codec_pkg::rgb888_t     rgb;
    logic [7:0]                     mono;
    display_codec_pkg::pixel_word_t yuv;
    display_codec_pkg::fmt_t        fmt_sel;
    logic                           override; // Forces RGB downstream

    modport src (
        output rgb, mono, yuv, fmt_sel, override
    );

    modport dst (
        input rgb, mono, yuv, fmt_sel, override
    );
endinterface

// All three converted words plus the resolved format
interface convert_if;
    display_codec_pkg::pixel_word_t rgb_word;
    display_codec_pkg::pixel_word_t mono_word;
    display_codec_pkg::pixel_word_t yuv_word;
    display_codec_pkg::fmt_t        active_fmt;

    modport src (
        output rgb_word, mono_word, yuv_word, active_fmt
    );

    modport dst (
        input rgb_word, mono_word, yuv_word, active_fmt
    );
endinterface

// File: design/display_codec_pkg.sv
// Display codec package with format codes and the pixel word types
package display_codec_pkg;

    // Format select codes, 3 to 7 are reserved
    typedef logic [2:0] fmt_t;

    localparam fmt_t FMT_RGB  = 3'd0;
    localparam fmt_t FMT_MONO = 3'd1;
    localparam fmt_t FMT_YUV  = 3'd2;

    // Incoming 24-bit colour pixel
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb888_t;

    // Truncated colour view of the display word
    typedef struct packed {
        logic [4:0] red;   // Top 5 bits of red
        logic [5:0] green; // Top 6 bits of green
        logic [4:0] blue;  // Top 5 bits of blue
    } rgb565_t;

    // Byte view of the display word
    // YUV carries luma high and chroma low, mono carries luma in both
    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] lo;
    } luma_chroma_t;

    // One 16-bit display word, read as colour or as two bytes
    typedef union packed {
        rgb565_t      rgb;
        luma_chroma_t lc;
    } pixel_word_t;

endpackage

// File: design/display_output_stage.sv
// Display output stage selecting the display word and driving format valid
`timescale 1ns/1ns

module display_output_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    convert_if.dst                         conv,
    output display_codec_pkg::pixel_word_t display_out,
    output logic                           format_valid
);

    // Word select on the resolved format
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            display_out  <= '0;
            format_valid <= 1'b0;
        end else begin
            case (conv.active_fmt)
                display_codec_pkg::FMT_RGB: begin
                    display_out  <= conv.rgb_word;
                    format_valid <= 1'b1;
                end
                display_codec_pkg::FMT_MONO: begin
                    display_out  <= conv.mono_word;
                    format_valid <= 1'b1;
                end
                display_codec_pkg::FMT_YUV: begin
                    display_out  <= conv.yuv_word;
                    format_valid <= 1'b1;
                end
                default: begin // Reserved codes 3 to 7
                    display_out  <= '0;
                    format_valid <= 1'b0;
                end
            endcase
        end
    end

    // No stale pixel leaks out on an invalid cycle
    zero_when_invalid_a : assert property (
        @(posedge clk) disable iff (!rst_n)
        !format_valid |-> (display_out == '0)
    );

endmodule

// File: design/format_converter.sv
// Format converter resolving the active format and building the three converted words
`timescale 1ns/1ns

module format_converter (
    input  logic   clk,
    input  logic   rst_n,
    capture_if.dst cap,
    convert_if.src conv
);

    display_codec_pkg::fmt_t        resolved_fmt;
    display_codec_pkg::pixel_word_t rgb_next;
    display_codec_pkg::pixel_word_t mono_next;

    // Override wins over any select including reserved codes
    always_comb begin
        if (cap.override) begin
            resolved_fmt = display_codec_pkg::FMT_RGB;
        end else begin
            resolved_fmt = cap.fmt_sel;
        end
    end

    // RGB888 to RGB565 by dropping the low bits
    always_comb begin
        rgb_next.rgb.red   = cap.rgb.red[7:3];
        rgb_next.rgb.green = cap.rgb.green[7:2];
        rgb_next.rgb.blue  = cap.rgb.blue[7:3];
    end

    // Mono byte copied into both halves
    always_comb begin
        mono_next.lc.hi = cap.mono;
        mono_next.lc.lo = cap.mono;
    end

    // All three words built every cycle for the output stage to pick from
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            conv.active_fmt <= display_codec_pkg::FMT_RGB;
            conv.rgb_word   <= '0;
            conv.mono_word  <= '0;
            conv.yuv_word   <= '0;
        end else begin
            conv.active_fmt <= resolved_fmt;
            conv.rgb_word   <= rgb_next;
            conv.mono_word  <= mono_next;
            conv.yuv_word   <= cap.yuv; // Passthrough
        end
    end

    // Captured override must reach the output stage as RGB
    override_to_rgb_a : assert property (
        @(posedge clk) disable iff (!rst_n)
        cap.override |=> (conv.active_fmt == display_codec_pkg::FMT_RGB)
    );

endmodule

// File: design/pixel_capture.sv
// Pixel capture stage registering all pixel inputs and control levels
`timescale 1ns/1ns

module pixel_capture (
    input  logic                           clk,
    input  logic                           rst_n,
    input  display_codec_pkg::rgb888_t     rgb_data,
    input  logic [7:0]                     mono_data,
    input  display_codec_pkg::pixel_word_t yuv_data,
    input  display_codec_pkg::fmt_t        format_select,
    input  logic                           priority_override,
    capture_if.src                         cap
);

    // Pad-side flops, one new sample every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cap.rgb      <= '0;
            cap.mono     <= '0;
            cap.yuv      <= '0;
            cap.fmt_sel  <= display_codec_pkg::FMT_RGB;
            cap.override <= 1'b0;
        end else begin
            cap.rgb      <= rgb_data;
            cap.mono     <= mono_data;
            cap.yuv      <= yuv_data;
            cap.fmt_sel  <= format_select;
            cap.override <= priority_override;
        end
    end

    // An unknown override would poison the format choice two stages on
    override_known_a : assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(cap.override)
    );

endmodule

// File: design/priority_display_codec.sv
// Priority display codec top level, a three stage pixel format pipeline
`timescale 1ns/1ns

module priority_display_codec (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [23:0] rgb_data,
    input  logic [7:0]  mono_data,
    input  logic [15:0] yuv_data,
    input  logic [2:0]  format_select,    // 0 RGB, 1 mono, 2 YUV, rest reserved
    input  logic        priority_override,
    output logic [15:0] display_out,
    output logic        format_valid
);

    capture_if cap_bus ();
    convert_if conv_bus ();

    // Stage 1, input flops
    pixel_capture pixel_capture_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .rgb_data          (rgb_data),
        .mono_data         (mono_data),
        .yuv_data          (yuv_data),
        .format_select     (format_select),
        .priority_override (priority_override),
        .cap               (cap_bus.src)
    );

    // Stage 2, format resolve and conversion
    format_converter format_converter_i (
        .clk   (clk),
        .rst_n (rst_n),
        .cap   (cap_bus.dst),
        .conv  (conv_bus.src)
    );

    // Stage 3, word select and valid flag
    display_output_stage display_output_stage_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .conv         (conv_bus.dst),
        .display_out  (display_out),
        .format_valid (format_valid)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile and run the display codec testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_priority_display_codec -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/Vtb_priority_display_codec > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    echo "Test run FAILED, see $LOG"
    exit 1
fi

echo "Test run PASSED"
exit 0

// File: sim/display_tests.txt
# Columns: rgb mono yuv select override expected_word expected_valid, all hex
# Words follow RGB565 truncation, mono in both bytes and YUV passthrough
# RGB conversion
FFFFFF 00 0000 0 0 FFFF 1
AAAAAA 00 0000 0 0 AD55 1
555555 00 0000 0 0 52AA 1
123456 00 0000 0 0 11AA 1
F80000 00 0000 0 0 F800 1
00FC00 00 0000 0 0 07E0 1
0000F8 00 0000 0 0 001F 1
# Mono replication with other sources ignored
123456 5A 1234 1 0 5A5A 1
000000 FF 0000 1 0 FFFF 1
FFFFFF 00 FFFF 1 0 0000 1
# YUV passthrough
000000 00 80F0 2 0 80F0 1
AAAAAA 55 1234 2 0 1234 1
# Reserved codes give a zero word and no valid
FFFFFF FF FFFF 3 0 0000 0
123456 5A 80F0 4 0 0000 0
AAAAAA AA AAAA 5 0 0000 0
555555 55 5555 6 0 0000 0
FFFFFF FF FFFF 7 0 0000 0
# Override forces RGB for any select
123456 5A 1234 1 1 11AA 1
AAAAAA 00 80F0 2 1 AD55 1
555555 FF FFFF 5 1 52AA 1
FFFFFF 00 0000 7 1 FFFF 1
F80000 33 4455 0 1 F800 1
# Back to back format changes
00FC00 C3 BEEF 2 0 BEEF 1
00FC00 C3 BEEF 1 0 C3C3 1
00FC00 C3 BEEF 6 0 0000 0
00FC00 C3 BEEF 0 0 07E0 1

// File: sim/tb_priority_display_codec.sv
// Testbench for the priority display codec, streaming file vectors through a delay queue
`timescale 1ns/1ns

module tb_priority_display_codec;

    // One line of the vector file
    typedef struct packed {
        display_codec_pkg::rgb888_t     rgb;
        logic [7:0]                     mono;
        display_codec_pkg::pixel_word_t yuv;
        display_codec_pkg::fmt_t        sel;
        logic                           ovr;
        display_codec_pkg::pixel_word_t exp_word;
        logic                           exp_valid;
    } vector_t;

    logic                           clk;
    logic                           rst_n;
    display_codec_pkg::rgb888_t     rgb_data;
    logic [7:0]                     mono_data;
    display_codec_pkg::pixel_word_t yuv_data;
    display_codec_pkg::fmt_t        format_select;
    logic                           priority_override;
    display_codec_pkg::pixel_word_t display_out;
    logic                           format_valid;

    vector_t vectors[$];
    int      pending_q[$]; // Vector numbers still in the pipeline
    int      pass_count;
    int      fail_count;
    bit      aborted;      // File or timeout trouble
    bit      vec_ok;

    priority_display_codec priority_display_codec_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .rgb_data          (rgb_data),
        .mono_data         (mono_data),
        .yuv_data          (yuv_data),
        .format_select     (format_select),
        .priority_override (priority_override),
        .display_out       (display_out),
        .format_valid      (format_valid)
    );

    always #10 clk = ~clk; // 20 ns period

    task automatic check_word(input display_codec_pkg::pixel_word_t expected,
                              input display_codec_pkg::pixel_word_t actual, input int num);
        if (actual !== expected) begin
            $display("Error: test %0d display_out expected 0x%04h actual 0x%04h",
                     num, expected, actual);
            vec_ok = 1'b0;
        end
    endtask

    task automatic check_valid(input logic expected, input logic actual, input int num);
        if (actual !== expected) begin
            $display("Error: test %0d format_valid expected 0x%01h actual 0x%01h",
                     num, expected, actual);
            vec_ok = 1'b0;
        end
    endtask

    task automatic finish_test(input int num);
        if (vec_ok) begin
            pass_count++;
            $display("Test %0d passed: display_out 0x%04h format_valid %0b",
                     num, display_out, format_valid);
        end else begin
            fail_count++;
            $display("Test %0d failed", num);
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          fields;
        string       line;
        logic [23:0] f_rgb;
        logic [7:0]  f_mono;
        logic [15:0] f_yuv;
        logic [2:0]  f_sel;
        logic        f_ovr;
        logic [15:0] f_word;
        logic        f_valid;
        vector_t     v;
        fd = $fopen("sim/display_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open sim/display_tests.txt for reading");
            aborted = 1'b1;
        end else begin
            while ($fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%h %h %h %h %h %h %h",
                                 f_rgb, f_mono, f_yuv, f_sel, f_ovr, f_word, f_valid);
                if (fields == 7) begin // Comment and blank lines give fewer fields
                    v.rgb       = f_rgb;
                    v.mono      = f_mono;
                    v.yuv       = f_yuv;
                    v.sel       = f_sel;
                    v.ovr       = f_ovr;
                    v.exp_word  = f_word;
                    v.exp_valid = f_valid;
                    vectors.push_back(v);
                end
            end
            $fclose(fd);
            if (vectors.size() == 0) begin
                $display("No test vectors found in sim/display_tests.txt");
                aborted = 1'b1;
            end
        end
    endtask

    task automatic drive_vector(input vector_t v);
        rgb_data          = v.rgb;
        mono_data         = v.mono;
        yuv_data          = v.yuv;
        format_select     = v.sel;
        priority_override = v.ovr;
    endtask

    task automatic wait_for_valid();
        int cycles;
        cycles = 0;
        while (format_valid !== 1'b1 && cycles < 20) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (format_valid !== 1'b1) begin
            $display("Timeout: format_valid did not rise within 20 cycles of reset release");
            aborted = 1'b1;
        end
    endtask

    // One vector in per cycle, each checked three edges after it was driven
    task automatic stream_vectors();
        int next;
        int num;
        next = 0;
        while (next < vectors.size() || pending_q.size() > 0) begin
            @(posedge clk);
            #2;
            if (pending_q.size() == 3 || next >= vectors.size()) begin
                num    = pending_q.pop_front();
                vec_ok = 1'b1;
                check_word(vectors[num].exp_word, display_out, num + 1);
                check_valid(vectors[num].exp_valid, format_valid, num + 1);
                finish_test(num + 1);
            end
            if (next < vectors.size()) begin
                drive_vector(vectors[next]);
                pending_q.push_back(next);
                next++;
            end
        end
    endtask

    initial begin
        clk               = 1'b0;
        rst_n             = 1'b0;
        rgb_data          = '0;
        mono_data         = '0;
        yuv_data          = '0;
        format_select     = display_codec_pkg::FMT_RGB;
        priority_override = 1'b0;
        pass_count        = 0;
        fail_count        = 0;
        aborted           = 1'b0;
        load_vectors();
        repeat (10) @(posedge clk);
        #2;
        vec_ok = 1'b1; // Test 0 covers reset and the first valid word
        check_word('0, display_out, 0);
        check_valid(1'b0, format_valid, 0);
        rst_n = 1'b1;
        wait_for_valid();
        if (!aborted) begin
            check_word('0, display_out, 0);
            finish_test(0);
            stream_vectors();
        end
        $display("Totals: %0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0 && !aborted) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
design/display_codec_pkg.sv
design/codec_ifs.sv
design/pixel_capture.sv
design/format_converter.sv
design/display_output_stage.sv
design/priority_display_codec.sv
sim/tb_priority_display_codec.sv
